//--- common/ctl_pkg.sv
// Shared control types for the 65C02 subset; interrupt, BRK/RTI and flag-update encodings are absent
package ctl_pkg;

    typedef logic [7:0] opcode_t;

    typedef enum logic [4:0] {
        INIT,
        SYNC,
        IMM0,
        IND0,
        IND1,
        IND2,
        DATA,
        ABS0,
        ABS1,
        ZERO,
        PULL,
        RDWR,
        RTS0,
        RTS1,
        RTS2,
        PUSH,
        JSR0,
        JSR1,
        JSR2,
        COND
    } state_t;

    typedef struct packed {
        logic rmw;                  // Hold address for a write-back cycle
        logic jmp;                  // Absolute address goes to PC
        logic ind;                  // One more indirection pass
        logic add_x;
        logic add_y;
        logic st;                   // Store to memory
    } insn_flags_t;

    typedef struct packed {
        logic [1:0] shift;
        logic [2:0] add;
        logic [1:0] carry;
        logic       ld;
        logic [1:0] dst;
        logic [3:0] src;
    } ctl_word_t;

    typedef struct packed {
        state_t      entry;
        insn_flags_t flags;
        ctl_word_t   word;
    } decode_t;

    typedef struct packed {
        logic       we;
        logic [1:0] dst;
        logic [3:0] src;
    } reg_op_t;

    typedef struct packed {
        logic       ldm;
        logic       bcd;
        logic [1:0] shift;
        logic [2:0] add;
        logic [1:0] carry;
    } alu_op_t;

    typedef struct packed {
        logic [6:0] pc_hold_sel;
        logic [1:0] abl_sel;
        logic [1:0] abl_op;
        logic       abl_ci;
    } ab_op_t;

    // Bits 1:0 select the ABL mux, bit 2 is the ABL carry in
    typedef enum logic [3:0] {
        AB_HOLD    = 4'b0000,       // AB kept, AHL <= DB
        AB_PC      = 4'b0001,       // AB <= PC
        AB_ABS_PC  = 4'b0010,       // {DB, AHL+XYZ}, PC <= AB+1
        AB_ZP      = 4'b0011,       // {00, DB+XYZ}
        AB_INC_PC  = 4'b0100,       // AB+1, PC <= AB
        AB_SP_INC  = 4'b0101,       // {01, SP+1}
        AB_BRANCH  = 4'b0111,       // AB + offset + 1
        AB_SP      = 4'b1000,       // {01, SP}, PC kept
        AB_SP_PC   = 4'b1001,       // {01, SP}, PC <= AB+1
        AB_ABS     = 4'b1010,       // {DB, AHL+XYZ}, PC kept
        AB_SP_HOLD = 4'b1011,       // {01, SP}, AHL kept
        AB_INC     = 4'b1100,       // AB+1, PC kept
        AB_ABS_INC = 4'b1110        // {DB, AHL+XYZ}+1
    } ab_mode_t;

    typedef enum logic [1:0] {
        DO_ALU,
        DO_P,
        DO_PCL,
        DO_PCH
    } do_sel_t;

    localparam logic [3:0] SRC_X = 4'b0000;
    localparam logic [3:0] SRC_Y = 4'b0001;
    localparam logic [3:0] SRC_A = 4'b0010;
    localparam logic [3:0] SRC_S = 4'b0011;
    localparam logic [3:0] SRC_Z = 4'b0111;

    localparam logic [1:0] DST_X = 2'b00;
    localparam logic [1:0] DST_Y = 2'b01;
    localparam logic [1:0] DST_A = 2'b10;
    localparam logic [1:0] DST_S = 2'b11;

    localparam logic [2:0] ADD_OR  = 3'b000;
    localparam logic [2:0] ADD_AND = 3'b001;
    localparam logic [2:0] ADD_XOR = 3'b010;
    localparam logic [2:0] ADD_ADD = 3'b011;
    localparam logic [2:0] ADD_INC = 3'b100;
    localparam logic [2:0] ADD_DEC = 3'b101;
    localparam logic [2:0] ADD_SUB = 3'b110;

    localparam logic [1:0] CI_NONE = 2'b00;
    localparam logic [1:0] CI_ONE  = 2'b01;
    localparam logic [1:0] CI_ADC  = 2'b11;
    localparam logic [1:0] SH_LEFT = 2'b10;

    localparam opcode_t OPC_BRA      = 8'h80;
    localparam opcode_t OPC_JSR      = 8'h20;
    localparam opcode_t OPC_RTS      = 8'h60;
    localparam opcode_t OPC_PHA      = 8'h48;
    localparam opcode_t OPC_PLA      = 8'h68;
    localparam opcode_t OPC_JMP      = 8'h4C;
    localparam opcode_t OPC_JMP_IND  = 8'h6C;
    localparam opcode_t OPC_JMP_INDX = 8'h7C;

endpackage

//--- design/decode/opcode_decoder.sv
`timescale 1ns/1ps
// Recognizes only the kept 65C02 subset; any other byte yields an empty word and SYNC entry
module opcode_decoder
    import ctl_pkg::*;
(
    input  opcode_t db,
    output decode_t dec
);

    logic [2:0] row;
    logic [3:0] col;
    logic       alu_grp;
    logic       known;
    state_t     col_entry;

    function automatic ctl_word_t mk_word(
        input logic [1:0] shift,
        input logic [2:0] add,
        input logic [1:0] carry,
        input logic       ld,
        input logic [1:0] dst,
        input logic [3:0] src
    );
        return '{shift, add, carry, ld, dst, src};
    endfunction

    assign row     = db[7:5];
    assign col     = db[3:0];
    assign alu_grp = (col[1:0] == 2'b01) || (db[4] && col == 4'h2);   // Columns 1, 5, 9, D, odd 2

    // Addressing class from the column and row bits
    always_comb begin
        casez (db)
            8'b????_0001: col_entry = IND0;     // (zp,X) and (zp),Y
            8'b???1_0010: col_entry = IND0;     // (zp)
            8'b1010_00?0: col_entry = IMM0;     // LDY/LDX #
            8'b???0_1001: col_entry = IMM0;
            8'b???1_1001: col_entry = ABS0;     // abs,Y
            8'b????_11??: col_entry = ABS0;
            8'b????_01??: col_entry = ZERO;
            default:      col_entry = SYNC;
        endcase
    end

    always_comb begin
        dec   = '{entry: SYNC, flags: '0, word: '0};
        known = 1'b1;
        if (alu_grp) begin
            dec.flags.add_x = (col == 4'h1 && !db[4]) ||
                              (db[4] && (col == 4'h5 || col == 4'hD));
            dec.flags.add_y = db[4] && (col == 4'h1 || col == 4'h9);
            dec.flags.st    = (row == 3'd4);
            case (row)
                3'd0:    dec.word = mk_word(2'b00, ADD_OR,  CI_NONE, 1'b1, DST_A, SRC_A);
                3'd1:    dec.word = mk_word(2'b00, ADD_AND, CI_NONE, 1'b1, DST_A, SRC_A);
                3'd2:    dec.word = mk_word(2'b00, ADD_XOR, CI_NONE, 1'b1, DST_A, SRC_A);
                3'd3:    dec.word = mk_word(2'b00, ADD_ADD, CI_ADC,  1'b1, DST_A, SRC_A);
                3'd4:    dec.word = mk_word(2'b00, ADD_INC, CI_NONE, 1'b0, DST_X, SRC_A);
                3'd5:    dec.word = mk_word(2'b00, ADD_OR,  CI_NONE, 1'b1, DST_A, SRC_Z);
                3'd6:    dec.word = mk_word(2'b00, ADD_SUB, CI_ONE,  1'b0, DST_X, SRC_A);
                default: dec.word = mk_word(2'b00, ADD_SUB, CI_ADC,  1'b1, DST_A, SRC_A);
            endcase
            known = (row != 3'd4) || (db == 8'h85) || (db == 8'h8D);   // Only STA zp/abs
        end else begin
            case (db)
                8'h84, 8'h8C: begin                                 // STY
                    dec.flags.st = 1'b1;
                    dec.word     = mk_word(2'b00, ADD_INC, CI_NONE, 1'b0, DST_X, SRC_Y);
                end
                8'h86, 8'h8E: begin                                 // STX
                    dec.flags.st = 1'b1;
                    dec.word     = mk_word(2'b00, ADD_INC, CI_NONE, 1'b0, DST_X, SRC_X);
                end
                8'h64, 8'h9C: begin                                 // STZ
                    dec.flags.st = 1'b1;
                    dec.word     = mk_word(2'b00, ADD_INC, CI_NONE, 1'b0, DST_X, SRC_Z);
                end
                8'h06, 8'h0E: begin                                 // ASL mem
                    dec.flags.rmw = 1'b1;
                    dec.word      = mk_word(SH_LEFT, ADD_OR, CI_NONE, 1'b0, DST_X, SRC_Z);
                end
                8'hE6, 8'hEE: begin                                 // INC mem
                    dec.flags.rmw = 1'b1;
                    dec.word      = mk_word(2'b00, ADD_INC, CI_ONE, 1'b0, DST_X, SRC_Z);
                end
                8'hA2:   dec.word = mk_word(2'b00, ADD_OR, CI_NONE, 1'b1, DST_X, SRC_Z);
                8'hA0:   dec.word = mk_word(2'b00, ADD_OR, CI_NONE, 1'b1, DST_Y, SRC_Z);
                OPC_PHA: begin
                    dec.flags.st = 1'b1;
                    dec.word     = mk_word(2'b00, ADD_INC, CI_NONE, 1'b0, DST_X, SRC_A);
                end
                OPC_PLA: dec.word = mk_word(2'b00, ADD_OR, CI_NONE, 1'b1, DST_A, SRC_Z);
                OPC_JSR, OPC_JMP: dec.flags.jmp = 1'b1;
                OPC_JMP_IND: begin
                    dec.flags.jmp = 1'b1;
                    dec.flags.ind = 1'b1;
                end
                OPC_JMP_INDX: begin
                    dec.flags.jmp   = 1'b1;
                    dec.flags.ind   = 1'b1;
                    dec.flags.add_x = 1'b1;
                end
                OPC_BRA, OPC_RTS: known = 1'b1;             // Sequencing only, empty word
                default: known = 1'b0;
            endcase
        end
        if (known) begin
            dec.entry = col_entry;
        end else begin
            dec.flags = '0;
            dec.word  = '0;
        end
    end

endmodule

//--- design/sequencer/state_sequencer.sv
`timescale 1ns/1ps
// Stack, JSR and BRA entries are taken from db directly; no interrupt sequences exist
module state_sequencer
    import ctl_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  decode_t     dec,
    input  opcode_t     db,
    output state_t      state,
    output insn_flags_t flags,
    output ctl_word_t   word,
    output logic        sync
);

    state_t next_state;

    assign sync = (state == SYNC);

    always_comb begin
        case (state)
            INIT: next_state = SYNC;
            SYNC: begin
                case (db)
                    OPC_BRA: next_state = COND;
                    OPC_JSR: next_state = JSR0;
                    OPC_RTS: next_state = RTS0;
                    OPC_PHA: next_state = PUSH;
                    OPC_PLA: next_state = PULL;
                    default: next_state = dec.entry;    // Column class or unknown
                endcase
            end
            IND0: next_state = IND1;
            IND1: next_state = IND2;
            IND2: next_state = DATA;
            IMM0: next_state = SYNC;
            ABS0: next_state = ABS1;
            ZERO: next_state = flags.rmw ? RDWR : DATA;
            ABS1: begin
                if (flags.ind) begin
                    next_state = ABS0;                  // Fetch the pointed-to address
                end else if (flags.jmp) begin
                    next_state = SYNC;
                end else if (flags.rmw) begin
                    next_state = RDWR;
                end else begin
                    next_state = DATA;
                end
            end
            RDWR: next_state = DATA;
            DATA: next_state = SYNC;
            PULL: next_state = DATA;
            PUSH: next_state = DATA;
            RTS0: next_state = RTS1;
            RTS1: next_state = RTS2;
            RTS2: next_state = SYNC;
            JSR0: next_state = JSR1;
            JSR1: next_state = JSR2;
            JSR2: next_state = ABS1;                    // jmp already latched
            COND: next_state = SYNC;
            default: next_state = SYNC;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= INIT;
            flags <= '0;
            word  <= '0;
        end else begin
            state <= next_state;
            if (state == SYNC) begin
                flags <= dec.flags;
                word  <= dec.word;
            end else if (state == ABS1) begin
                flags.ind   <= 1'b0;                    // Stops the indirection loop
                flags.add_x <= 1'b0;                    // X only indexes the JMP pointer
            end
        end
    end

endmodule

//--- design/encode/bus_op_encoder.sv
`timescale 1ns/1ps
// The bcd bit is always low since decimal mode is not handled here
module bus_op_encoder
    import ctl_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  state_t      state,
    input  insn_flags_t flags,
    input  ctl_word_t   word,
    output logic        we,
    output reg_op_t     reg_op,
    output alu_op_t     alu_op,
    output do_sel_t     do_op
);

    logic [3:0] idx_src;

    assign idx_src = flags.add_x ? SRC_X : (flags.add_y ? SRC_Y : SRC_Z);

    // Write lands one cycle after the addressing state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we <= 1'b0;
        end else begin
            case (state)
                PUSH, RDWR, JSR0, JSR1: we <= 1'b1;
                ZERO, ABS1:             we <= flags.st;
                default:                we <= 1'b0;
            endcase
        end
    end

    always_comb begin
        reg_op = '{we: 1'b0, dst: DST_X, src: SRC_Z};
        case (state)
            PUSH, PULL, JSR0, JSR1, RTS0, RTS1: begin
                reg_op = '{we: 1'b1, dst: DST_S, src: SRC_S};   // Stack pointer update
            end
            IND0: reg_op.src = flags.add_x ? SRC_X : SRC_Z;
            IND2: reg_op.src = flags.add_y ? SRC_Y : SRC_Z;
            ZERO, ABS1: reg_op.src = idx_src;
            SYNC: reg_op = '{we: word.ld, dst: word.dst, src: word.src};
            DATA: begin
                reg_op.dst = word.dst;                  // Store data source
                reg_op.src = word.src;
            end
            default: reg_op.src = SRC_Z;
        endcase
    end

    always_comb begin
        alu_op = '0;
        case (state)
            PUSH, JSR0, JSR1: alu_op.add = ADD_DEC;
            PULL, RTS0, RTS1: begin
                alu_op.add   = ADD_INC;
                alu_op.carry = CI_ONE;
            end
            IMM0, RDWR: alu_op.ldm = 1'b1;              // Load M
            SYNC: begin
                alu_op.shift = word.shift;
                alu_op.add   = word.add;
                alu_op.carry = word.carry;
            end
            DATA: begin
                alu_op.ldm   = !flags.st;               // Loads and RMW take M
                alu_op.shift = word.shift;
                alu_op.add   = word.add;
                alu_op.carry = word.carry;
            end
            default: alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            JSR1:    do_op = DO_PCH;                    // Return address high first
            JSR2:    do_op = DO_PCL;
            default: do_op = DO_ALU;
        endcase
    end

endmodule

//--- design/encode/addr_op_encoder.sv
`timescale 1ns/1ps
// BRA offset sign is read from db in COND; modes outside the table give all-zero controls
module addr_op_encoder
    import ctl_pkg::*;
(
    input  state_t  state,
    input  logic    cond,
    input  opcode_t db,
    output ab_op_t  ab_op
);

    ab_mode_t mode;
    logic     back;

    assign back = cond & db[7];                         // Taken backward branch

    always_comb begin
        case (state)
            INIT, RDWR:       mode = AB_HOLD;
            DATA, JSR2:       mode = AB_PC;
            SYNC, ABS0, IMM0: mode = AB_INC_PC;
            ABS1:             mode = AB_ABS_PC;
            IND0, ZERO:       mode = AB_ZP;
            IND1:             mode = AB_INC;
            IND2:             mode = AB_ABS;
            PULL, RTS0, RTS1: mode = AB_SP_INC;
            PUSH:             mode = AB_SP_HOLD;
            RTS2:             mode = AB_ABS_INC;
            JSR0:             mode = AB_SP_PC;
            JSR1:             mode = AB_SP;
            COND:             mode = AB_BRANCH;
            default:          mode = AB_HOLD;
        endcase
    end

    // Fields: pc_hold_sel, abl_sel, abl_op, abl_ci
    always_comb begin
        case (mode)
            AB_HOLD:    ab_op = {7'b001_0110, mode[1:0], 2'b11, mode[2]};
            AB_PC:      ab_op = {7'b000_1010, mode[1:0], 2'b10, mode[2]};
            AB_ABS_PC:  ab_op = {7'b111_1110, mode[1:0], 2'b01, mode[2]};
            AB_ZP:      ab_op = {7'b111_0000, mode[1:0], 2'b01, mode[2]};
            AB_INC_PC:  ab_op = {7'b011_0110, mode[1:0], 2'b11, mode[2]};
            AB_SP_INC:  ab_op = {7'b011_0001, mode[1:0], 2'b00, mode[2]};
            AB_BRANCH: begin
                if (back) begin
                    ab_op = {7'b011_0111, mode[1:0], 2'b11, mode[2]};   // ABH - 1 path
                end else begin
                    ab_op = {7'b011_0110, mode[1:0], 2'b11, mode[2]};
                end
            end
            AB_SP:      ab_op = {7'b000_0001, mode[1:0], 2'b00, mode[2]};
            AB_SP_PC:   ab_op = {7'b111_0001, mode[1:0], 2'b00, mode[2]};
            AB_ABS:     ab_op = {7'b001_1110, mode[1:0], 2'b01, mode[2]};
            AB_SP_HOLD: ab_op = {7'b010_0001, mode[1:0], 2'b00, mode[2]};
            AB_INC:     ab_op = {7'b001_0110, mode[1:0], 2'b11, mode[2]};
            AB_ABS_INC: ab_op = {7'b001_1110, mode[1:0], 2'b01, mode[2]};
            default:    ab_op = '0;
        endcase
    end

endmodule

//--- design/ctl_top.sv
`timescale 1ns/1ps
// Control unit of the kept 65C02 subset; no interrupt, RDY or status-flag outputs
module ctl_top
    import ctl_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  opcode_t db,
    input  logic    cond,
    output logic    sync,
    output logic    we,
    output ab_op_t  ab_op,
    output reg_op_t reg_op,
    output alu_op_t alu_op,
    output do_sel_t do_op
);

    decode_t     dec;
    state_t      state;
    insn_flags_t flags;
    ctl_word_t   word;

    opcode_decoder u_decode (
        .db  (db),
        .dec (dec)
    );

    state_sequencer u_seq (
        .clk    (clk),
        .arst_n (arst_n),
        .dec    (dec),
        .db     (db),
        .state  (state),
        .flags  (flags),
        .word   (word),
        .sync   (sync)
    );

    bus_op_encoder u_bus (
        .clk    (clk),
        .arst_n (arst_n),
        .state  (state),
        .flags  (flags),
        .word   (word),
        .we     (we),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .do_op  (do_op)
    );

    addr_op_encoder u_addr (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

endmodule

//--- test/ctl_model.svh
// Predicts only the kept 65C02 subset; every other byte is expected to act as a one-cycle unknown
`ifndef CTL_MODEL_SVH
`define CTL_MODEL_SVH

typedef enum int {
    CL_UNKNOWN, CL_BRA, CL_IMM, CL_ZP_LOAD, CL_ZP_STORE, CL_ZP_RMW,
    CL_ABS_LOAD, CL_ABS_STORE, CL_ABS_RMW, CL_JMP_ABS, CL_JMP_IND,
    CL_IND, CL_PHA, CL_PLA, CL_RTS, CL_JSR
} insn_class_t;

function automatic insn_class_t insn_class(input opcode_t op);
    logic [3:0] col;
    col = op[3:0];
    case (op)
        8'h80:                      return CL_BRA;
        8'h20:                      return CL_JSR;
        8'h60:                      return CL_RTS;
        8'h48:                      return CL_PHA;
        8'h68:                      return CL_PLA;
        8'h4C:                      return CL_JMP_ABS;
        8'h6C, 8'h7C:               return CL_JMP_IND;
        8'hA0, 8'hA2:               return CL_IMM;      // LDY/LDX #
        8'h84, 8'h85, 8'h86, 8'h64: return CL_ZP_STORE;
        8'h8C, 8'h8D, 8'h8E, 8'h9C: return CL_ABS_STORE;
        8'h06, 8'hE6:               return CL_ZP_RMW;
        8'h0E, 8'hEE:               return CL_ABS_RMW;
        default:                    ;
    endcase
    if (op[7:5] == 3'd4) begin
        return CL_UNKNOWN;                              // Store row, only STA kept
    end
    case (col)
        4'h1:    return CL_IND;
        4'h2:    return op[4] ? CL_IND : CL_UNKNOWN;    // (zp) form
        4'h5:    return CL_ZP_LOAD;
        4'h9:    return op[4] ? CL_ABS_LOAD : CL_IMM;   // abs,Y or #
        4'hD:    return CL_ABS_LOAD;
        default: return CL_UNKNOWN;
    endcase
endfunction

function automatic int class_len(input insn_class_t cl);
    case (cl)
        CL_UNKNOWN:                                        return 1;
        CL_BRA, CL_IMM:                                    return 2;
        CL_ZP_LOAD, CL_ZP_STORE, CL_JMP_ABS, CL_PHA, CL_PLA: return 3;
        CL_ZP_RMW, CL_ABS_LOAD, CL_ABS_STORE, CL_RTS:       return 4;
        default:                                           return 5;
    endcase
endfunction

function automatic int class_writes(input insn_class_t cl);
    case (cl)
        CL_ZP_STORE, CL_ABS_STORE, CL_ZP_RMW, CL_ABS_RMW, CL_PHA: return 1;
        CL_JSR:                                                 return 2;
        default:                                                return 0;
    endcase
endfunction

// Cycles right after the fetch that move the stack pointer
function automatic int stack_cycles(input insn_class_t cl);
    case (cl)
        CL_PHA, CL_PLA: return 1;
        CL_JSR, CL_RTS: return 2;
        default:        return 0;
    endcase
endfunction

function automatic alu_op_t stack_alu_op(input logic push);
    alu_op_t a;
    a = '0;
    if (push) begin
        a.add = ADD_DEC;
    end else begin
        a.add   = ADD_INC;
        a.carry = CI_ONE;                               // Pull adds one
    end
    return a;
endfunction

function automatic ab_op_t bra_ab_op(input logic back);
    ab_op_t a;
    a.pc_hold_sel = back ? 7'b011_0111 : 7'b011_0110;
    a.abl_sel     = 2'b11;
    a.abl_op      = 2'b11;
    a.abl_ci      = 1'b1;
    return a;
endfunction

// Row 0 ORA, row 3 ADC, row 5 LDA
function automatic reg_op_t imm_reg_op(input opcode_t op);
    return '{we: 1'b1, dst: DST_A, src: (op[7:5] == 3'd5) ? SRC_Z : SRC_A};
endfunction

function automatic alu_op_t imm_alu_op(input opcode_t op);
    alu_op_t a;
    a = '0;
    if (op[7:5] == 3'd3) begin
        a.add   = ADD_ADD;
        a.carry = CI_ADC;
    end else begin
        a.add = ADD_OR;
    end
    return a;
endfunction

`endif

//--- test/ctl_tb.sv
`timescale 1ns/1ps
// Random opcode stream from a fixed seed; checks cycle counts, writes, stack, BRA, immediate and data-out ops
module ctl_tb
    import ctl_pkg::*;
();

    `include "ctl_model.svh"

    localparam int NUM_INSN   = 400;
    localparam int MAX_CYCLES = NUM_INSN * 6 + 100;

    logic    clk;
    logic    arst_n;
    opcode_t db;
    logic    cond;
    logic    sync;
    logic    we;
    ab_op_t  ab_op;
    reg_op_t reg_op;
    alu_op_t alu_op;
    do_sel_t do_op;

    integer  seed     = 32'hc9b2;
    int      cycles   = 0;
    int      len_errs = 0;
    int      we_errs  = 0;
    int      op_errs  = 0;
    int      lvl_errs = 0;

    ctl_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .db     (db),
        .cond   (cond),
        .sync   (sync),
        .we     (we),
        .ab_op  (ab_op),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .do_op  (do_op)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the instruction stream did not finish within %0d cycles",
                     MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            lvl_errs++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_state_len(input string name, input int exp, input int act);
        if (exp != act) begin
            len_errs++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_we_count(input string name, input int exp, input int act);
        if (exp != act) begin
            we_errs++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_reg_op(input string name, input reg_op_t exp, input reg_op_t act);
        if (exp !== act) begin
            op_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (exp !== act) begin
            op_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ab_op(input string name, input ab_op_t exp, input ab_op_t act);
        if (exp !== act) begin
            op_errs++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_do_op(input string name, input do_sel_t exp, input do_sel_t act);
        if (exp !== act) begin
            op_errs++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Opcodes drawn often so that stack, branch and immediate cases all show up
    function automatic opcode_t featured_op(input logic [3:0] idx);
        case (idx)
            4'h0:    return OPC_BRA;
            4'h1:    return OPC_JSR;
            4'h2:    return OPC_RTS;
            4'h3:    return OPC_PHA;
            4'h4:    return OPC_PLA;
            4'h5:    return OPC_JMP_IND;
            4'h6:    return OPC_JMP_INDX;
            4'h7:    return OPC_JMP;
            4'h8:    return 8'hA9;
            4'h9:    return 8'h09;
            4'hA:    return 8'h69;
            4'hB:    return 8'h85;
            4'hC:    return 8'hE6;
            4'hD:    return 8'h0E;
            4'hE:    return 8'hA2;
            default: return 8'hA0;
        endcase
    endfunction

    initial begin
        opcode_t     op;
        opcode_t     prev;
        insn_class_t cl;
        logic [31:0] r;
        logic        in_sync;
        logic        prev_valid;
        int          pos;                               // Cycle index inside the instruction
        int          we_seen;
        int          done;
        do_sel_t     exp_do;

        arst_n     = 1'b0;
        db         = '0;
        cond       = 1'b0;
        op         = '0;
        prev       = '0;
        cl         = CL_UNKNOWN;
        prev_valid = 1'b0;
        pos        = 0;
        we_seen    = 0;
        done       = 0;

        repeat (8) @(negedge clk);
        check_level("reset sync", 1'b0, sync);
        check_level("reset we", 1'b0, we);
        arst_n = 1'b1;
        #1;
        check_level("init sync", 1'b0, sync);
        check_level("init we", 1'b0, we);
        @(negedge clk);
        check_level("first sync", 1'b1, sync);           // Second cycle after release

        while (done < NUM_INSN) begin
            in_sync = sync;
            if (in_sync) begin
                if (pos > 0) begin
                    check_state_len($sformatf("length %02h", op), class_len(cl), pos);
                    check_we_count($sformatf("writes %02h", op), class_writes(cl), we_seen);
                    done++;
                end
                prev       = op;
                prev_valid = (pos > 0);
                r          = $random(seed);
                if (r[1:0] == 2'b00) begin
                    op = r[15:8];                       // Any byte
                end else if (r[1:0] == 2'b01) begin
                    op = featured_op(r[7:4]);
                end else begin
                    do begin
                        r  = $random(seed);
                        op = r[7:0];
                    end while (insn_class(op) == CL_UNKNOWN);
                end
                cl      = insn_class(op);
                pos     = 0;
                we_seen = 0;
                r       = $random(seed);
                db      = op;
                cond    = r[8];
            end else begin
                r    = $random(seed);
                db   = r[7:0];
                cond = r[8];
            end
            #1;
            pos++;
            if (we) begin
                we_seen++;
            end
            if (in_sync && prev_valid && (prev == 8'h09 || prev == 8'h69 || prev == 8'hA9)) begin
                check_reg_op($sformatf("imm reg_op %02h", prev), imm_reg_op(prev), reg_op);
                check_alu_op($sformatf("imm alu_op %02h", prev), imm_alu_op(prev), alu_op);
            end
            if (!in_sync && pos <= 1 + stack_cycles(cl)) begin
                check_reg_op($sformatf("stack reg_op %02h", op),
                             '{we: 1'b1, dst: DST_S, src: SRC_S}, reg_op);
                check_alu_op($sformatf("stack alu_op %02h", op),
                             stack_alu_op(cl == CL_PHA || cl == CL_JSR), alu_op);
            end
            if (!in_sync && cl == CL_BRA && pos == 2) begin
                check_ab_op("bra ab_op", bra_ab_op(cond & db[7]), ab_op);
            end
            exp_do = DO_ALU;
            if (!in_sync && cl == CL_JSR && pos == 3) begin
                exp_do = DO_PCH;                        // Return address high byte
            end else if (!in_sync && cl == CL_JSR && pos == 4) begin
                exp_do = DO_PCL;
            end
            check_do_op($sformatf("do_op %02h", op), exp_do, do_op);
            @(negedge clk);
        end

        $display("Errors: length %0d, writes %0d, operations %0d, levels %0d",
                 len_errs, we_errs, op_errs, lvl_errs);
        if (len_errs + we_errs + op_errs + lvl_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+test
common/ctl_pkg.sv
design/decode/opcode_decoder.sv
design/sequencer/state_sequencer.sv
design/encode/bus_op_encoder.sv
design/encode/addr_op_encoder.sv
design/ctl_top.sv
test/ctl_tb.sv
